// ==== src/aluPkg.sv ====
package aluPkg;

  // command numbers as seen on the cmd register
  typedef enum logic [2:0] {
    cmdAdd  = 3'd0,
    cmdSub  = 3'd1,
    cmdXor  = 3'd2,
    cmdSlt  = 3'd3,
    cmdAnd  = 3'd4,
    cmdNand = 3'd5,
    cmdNor  = 3'd6,
    cmdOr   = 3'd7
  } aluCmdE;

  // which unit feeds the output mux
  typedef enum logic [2:0] {
    unitAddSub  = 3'd0,
    unitXor     = 3'd1,
    unitSlt     = 3'd2,
    unitAndNand = 3'd3,
    unitNorOr   = 3'd4
  } unitSelE;

  typedef struct packed {
    unitSelE unitSel;
    logic    invertB;
    logic    invertOut;
  } aluCtrlT;

  // ordered so that carry lands in bit 0 of the flags register
  typedef struct packed {
    logic overflow;
    logic zero;
    logic carry;
  } aluFlagsT;

endpackage

// ==== src/axilPkg.sv ====
package axilPkg;

  localparam int addrBits = 8;
  localparam int dataBits = 32;

  typedef struct packed {
    logic                  awvalid;
    logic [addrBits-1:0]   awaddr;
    logic                  wvalid;
    logic [dataBits-1:0]   wdata;
    logic [dataBits/8-1:0] wstrb;
    logic                  bready;
    logic                  arvalid;
    logic [addrBits-1:0]   araddr;
    logic                  rready;
  } axilReqT;

  typedef struct packed {
    logic                awready;
    logic                wready;
    logic                bvalid;
    logic [1:0]          bresp;
    logic                arready;
    logic                rvalid;
    logic [dataBits-1:0] rdata;
    logic [1:0]          rresp;
  } axilRspT;

  localparam logic [1:0] respOkay   = 2'b00;
  localparam logic [1:0] respSlvErr = 2'b10;

  // register map
  localparam logic [addrBits-1:0] offOpA    = 8'h00;
  localparam logic [addrBits-1:0] offOpB    = 8'h04;
  localparam logic [addrBits-1:0] offCmd    = 8'h08;
  localparam logic [addrBits-1:0] offResult = 8'h0C;
  localparam logic [addrBits-1:0] offFlags  = 8'h10;

endpackage

// ==== src/aluControlLut.sv ====
`timescale 1ns/1ps

module aluControlLut (
  input  aluPkg::aluCmdE cmd,
  output aluPkg::aluCtrlT ctrl
);

  always_comb begin
    ctrl.unitSel   = aluPkg::unitAddSub;
    ctrl.invertB   = 1'b0;
    ctrl.invertOut = 1'b0;
    case (cmd)
      aluPkg::cmdAdd: begin
        ctrl.unitSel = aluPkg::unitAddSub;
      end
      aluPkg::cmdSub: begin
        ctrl.unitSel = aluPkg::unitAddSub;
        ctrl.invertB = 1'b1;
      end
      aluPkg::cmdXor: begin
        ctrl.unitSel = aluPkg::unitXor;
      end
      aluPkg::cmdSlt: begin
        ctrl.unitSel = aluPkg::unitSlt;
      end
      aluPkg::cmdAnd: begin
        ctrl.unitSel = aluPkg::unitAndNand;
      end
      aluPkg::cmdNand: begin
        ctrl.unitSel   = aluPkg::unitAndNand;
        ctrl.invertOut = 1'b1;
      end
      aluPkg::cmdNor: begin
        ctrl.unitSel   = aluPkg::unitNorOr;
        ctrl.invertOut = 1'b1;
      end
      aluPkg::cmdOr: begin
        ctrl.unitSel = aluPkg::unitNorOr;
      end
      default: begin
        ctrl.unitSel = aluPkg::unitAddSub;
      end
    endcase
  end

  // the output mux only knows five units
  always_comb begin
    unitSelValid: assert final (ctrl.unitSel inside {aluPkg::unitAddSub, aluPkg::unitXor,
        aluPkg::unitSlt, aluPkg::unitAndNand, aluPkg::unitNorOr})
      else $error("control lookup produced unknown unit %0d", ctrl.unitSel);
  end

endmodule

// ==== src/addSub.sv ====
`timescale 1ns/1ps

module addSub (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  logic        subtract,
  output logic [31:0] sum,
  output aluPkg::aluFlagsT flags
);

  // carry[i] is the carry into bit i
  logic [32:0] carry;
  logic [31:0] bEff;
  logic [31:0] halfSum;

  // two's complement subtract: invert b and carry in a one
  assign carry[0] = subtract;

  genvar i;
  generate
    for (i = 0; i < 32; i++) begin : g_stage
      assign bEff[i]      = b[i] ^ subtract;
      assign halfSum[i]   = a[i] ^ bEff[i];
      assign sum[i]       = halfSum[i] ^ carry[i];
      assign carry[i + 1] = (a[i] & bEff[i]) | (halfSum[i] & carry[i]);
    end
  endgenerate

  assign flags.carry    = carry[32];
  // signed overflow when carry into and out of the sign bit differ
  assign flags.overflow = carry[31] ^ carry[32];
  assign flags.zero     = ~|sum;

endmodule

// ==== src/aluOutputSelect.sv ====
`timescale 1ns/1ps

module aluOutputSelect (
  input  logic [31:0] operandA,
  input  logic [31:0] operandB,
  input  aluPkg::aluCtrlT ctrl,
  output logic [31:0] result,
  output aluPkg::aluFlagsT flags
);

  logic [31:0] addSubResult;
  logic [31:0] sltDiff;
  logic [31:0] sltResult;
  logic [31:0] xorResult;
  logic [31:0] andNandResult;
  logic [31:0] norOrResult;
  logic [31:0] invertMask;
  aluPkg::aluFlagsT addSubFlags;
  aluPkg::aluFlagsT sltFlags;

  addSub u_addSub (
    .a        (operandA),
    .b        (operandB),
    .subtract (ctrl.invertB),
    .sum      (addSubResult),
    .flags    (addSubFlags)
  );

  // comparator always subtracts, independent of invertB
  addSub u_sltSub (
    .a        (operandA),
    .b        (operandB),
    .subtract (1'b1),
    .sum      (sltDiff),
    .flags    (sltFlags)
  );

  // sign of a-b, corrected when the subtraction overflowed
  assign sltResult = {31'b0, sltDiff[31] ^ sltFlags.overflow};

  assign invertMask    = {32{ctrl.invertOut}};
  assign xorResult     = operandA ^ operandB;
  assign andNandResult = (operandA & operandB) ^ invertMask;
  assign norOrResult   = (operandA | operandB) ^ invertMask;

  always_comb begin
    flags = '0;
    case (ctrl.unitSel)
      aluPkg::unitAddSub: begin
        result = addSubResult;
        flags  = addSubFlags;
      end
      aluPkg::unitXor:     result = xorResult;
      aluPkg::unitSlt:     result = sltResult;
      aluPkg::unitAndNand: result = andNandResult;
      aluPkg::unitNorOr:   result = norOrResult;
      default:             result = '0;
    endcase
  end

  always_comb begin
    flagsOnlyFromAddSub: assert final (ctrl.unitSel == aluPkg::unitAddSub || flags == '0)
      else $error("non-arithmetic unit %0d reported flags %b", ctrl.unitSel, flags);
  end

endmodule

// ==== src/aluCore.sv ====
`timescale 1ns/1ps

module aluCore (
  input  logic [31:0] operandA,
  input  logic [31:0] operandB,
  input  aluPkg::aluCmdE cmd,
  output logic [31:0] result,
  output aluPkg::aluFlagsT flags
);

  aluPkg::aluCtrlT ctrl;

  // first stage: command to unit select and invert bits
  aluControlLut u_controlLut (
    .cmd  (cmd),
    .ctrl (ctrl)
  );

  // second stage: all units in parallel, one picked
  aluOutputSelect u_outputSelect (
    .operandA (operandA),
    .operandB (operandB),
    .ctrl     (ctrl),
    .result   (result),
    .flags    (flags)
  );

endmodule

// ==== src/aluAxilRegs.sv ====
`timescale 1ns/1ps

module aluAxilRegs #(
  parameter int addrWidth = 8
) (
  input  logic             clk,
  input  logic             rstN,
  input  axilPkg::axilReqT req,
  output axilPkg::axilRspT rsp,
  output logic [31:0]      operandA,
  output logic [31:0]      operandB,
  output aluPkg::aluCmdE   cmd,
  input  logic [31:0]      result,
  input  aluPkg::aluFlagsT flags
);

  logic [addrWidth-1:0] wrAddr;
  logic [addrWidth-1:0] rdAddr;
  logic                 awReady;
  logic                 bValid;
  logic [1:0]           bResp;
  logic                 arReady;
  logic                 rValid;
  logic [1:0]           rResp;
  logic [31:0]          rData;
  logic                 wrAccept;
  logic                 rdAccept;
  logic                 wrErr;
  logic                 rdErr;
  logic [31:0]          rdNext;

  function automatic logic [31:0] mergeBytes(logic [31:0] old, logic [31:0] data,
                                             logic [3:0] strb);
    logic [31:0] merged;
    merged = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = data[8*i +: 8];
      end
    end
    return merged;
  endfunction

  assign wrAddr   = req.awaddr[addrWidth-1:0];
  assign rdAddr   = req.araddr[addrWidth-1:0];
  assign wrAccept = awReady && req.awvalid && req.wvalid;
  assign rdAccept = arReady && req.arvalid;

  // only the operand and command registers are writable
  assign wrErr = !(wrAddr == addrWidth'(axilPkg::offOpA) ||
                   wrAddr == addrWidth'(axilPkg::offOpB) ||
                   wrAddr == addrWidth'(axilPkg::offCmd));

  always_comb begin
    rdErr  = 1'b0;
    rdNext = '0;
    case (rdAddr)
      addrWidth'(axilPkg::offOpA):    rdNext = operandA;
      addrWidth'(axilPkg::offOpB):    rdNext = operandB;
      addrWidth'(axilPkg::offCmd):    rdNext = {29'b0, cmd};
      addrWidth'(axilPkg::offResult): rdNext = result;
      addrWidth'(axilPkg::offFlags):  rdNext = {29'b0, flags};
      default:                        rdErr  = 1'b1;
    endcase
  end

  // write channel, address and data taken together
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      awReady  <= 1'b0;
      bValid   <= 1'b0;
      bResp    <= axilPkg::respOkay;
      operandA <= '0;
      operandB <= '0;
      cmd      <= aluPkg::cmdAdd;
    end else begin
      awReady <= req.awvalid && req.wvalid && !awReady && !bValid;
      if (wrAccept) begin
        bValid <= 1'b1;
        bResp  <= wrErr ? axilPkg::respSlvErr : axilPkg::respOkay;
        if (wrAddr == addrWidth'(axilPkg::offOpA)) begin
          operandA <= mergeBytes(operandA, req.wdata, req.wstrb);
        end
        if (wrAddr == addrWidth'(axilPkg::offOpB)) begin
          operandB <= mergeBytes(operandB, req.wdata, req.wstrb);
        end
        // cmd keeps only its low three bits
        if (wrAddr == addrWidth'(axilPkg::offCmd) && req.wstrb[0]) begin
          cmd <= aluPkg::aluCmdE'(req.wdata[2:0]);
        end
      end else if (bValid && req.bready) begin
        bValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      arReady <= 1'b0;
      rValid  <= 1'b0;
    end else begin
      arReady <= req.arvalid && !arReady && !rValid;
      if (rdAccept) begin
        rValid <= 1'b1;
      end else if (rValid && req.rready) begin
        rValid <= 1'b0;
      end
    end
  end

  // read data frozen at acceptance
  always_ff @(posedge clk) begin
    if (rdAccept) begin
      rData <= rdNext;
      rResp <= rdErr ? axilPkg::respSlvErr : axilPkg::respOkay;
    end
  end

  assign rsp.awready = awReady;
  assign rsp.wready  = awReady;
  assign rsp.bvalid  = bValid;
  assign rsp.bresp   = bResp;
  assign rsp.arready = arReady;
  assign rsp.rvalid  = rValid;
  assign rsp.rdata   = rData;
  assign rsp.rresp   = rResp;

  bValidHeld: assert property (@(posedge clk) disable iff (!rstN)
    rsp.bvalid && !req.bready |=> rsp.bvalid);
  rValidHeld: assert property (@(posedge clk) disable iff (!rstN)
    rsp.rvalid && !req.rready |=> rsp.rvalid);
  rDataStable: assert property (@(posedge clk) disable iff (!rstN)
    rsp.rvalid && !req.rready |=> $stable(rsp.rdata) && $stable(rsp.rresp));

endmodule

// ==== src/aluSubsystem.sv ====
`timescale 1ns/1ps

module aluSubsystem #(
  parameter int addrWidth = 8
) (
  input  logic             clk,
  input  logic             rstN,
  input  axilPkg::axilReqT req,
  output axilPkg::axilRspT rsp
);

  logic [31:0]      operandA;
  logic [31:0]      operandB;
  logic [31:0]      result;
  aluPkg::aluCmdE   cmd;
  aluPkg::aluFlagsT flags;

  aluAxilRegs #(
    .addrWidth (addrWidth)
  ) u_aluAxilRegs (
    .clk      (clk),
    .rstN     (rstN),
    .req      (req),
    .rsp      (rsp),
    .operandA (operandA),
    .operandB (operandB),
    .cmd      (cmd),
    .result   (result),
    .flags    (flags)
  );

  // purely combinational, result follows the registers in the same cycle
  aluCore u_aluCore (
    .operandA (operandA),
    .operandB (operandB),
    .cmd      (cmd),
    .result   (result),
    .flags    (flags)
  );

endmodule

// ==== tb/aluScoreboard.sv ====
`timescale 1ns/1ps

module aluScoreboard (
  input  logic             clk,
  input  logic             rstN,
  input  axilPkg::axilReqT req,
  input  axilPkg::axilRspT rsp,
  input  int               testId,
  output int               errorCount,
  output int               testsRun,
  output int               testsFailed
);

  logic [31:0] modelA;
  logic [31:0] modelB;
  logic [2:0]  modelCmd;
  // {rresp, rdata} captured when the read is accepted
  logic [33:0] expRd[$];
  logic [1:0]  expB[$];
  logic [33:0] expected;
  logic [31:0] heldData;
  logic        heldValid;
  int          lastTestId = -1;
  int          testChecks;
  int          testErrors;

  function automatic string testName(int id);
    case (id)
      0: return "reset";
      1: return "arithmetic";
      2: return "logicSlt";
      3: return "byteStrobes";
      4: return "decodeErrors";
      5: return "backPressure";
      default: return "idle";
    endcase
  endfunction

  // returns {overflow, zero, carry, result}
  function automatic logic [34:0] aluModel(logic [31:0] a, logic [31:0] b, logic [2:0] cmd);
    logic [32:0] wide;
    logic [31:0] r;
    logic        c;
    logic        v;
    c = 1'b0;
    v = 1'b0;
    case (cmd)
      3'd0: begin
        wide = {1'b0, a} + {1'b0, b};
        r = wide[31:0];
        c = wide[32];
        v = (a[31] == b[31]) && (r[31] != a[31]);
      end
      3'd1: begin
        // carry out means no borrow
        wide = {1'b0, a} - {1'b0, b};
        r = wide[31:0];
        c = ~wide[32];
        v = (a[31] != b[31]) && (r[31] != a[31]);
      end
      3'd2: r = a ^ b;
      3'd3: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd4: r = a & b;
      3'd5: r = ~(a & b);
      3'd6: r = ~(a | b);
      default: r = a | b;
    endcase
    return {v, (cmd <= 3'd1) && (r == 32'd0), c, r};
  endfunction

  function automatic logic [33:0] readModel(logic [7:0] addr);
    logic [34:0] alu;
    alu = aluModel(modelA, modelB, modelCmd);
    case (addr)
      axilPkg::offOpA:   return {axilPkg::respOkay, modelA};
      axilPkg::offOpB:   return {axilPkg::respOkay, modelB};
      axilPkg::offCmd:   return {axilPkg::respOkay, 29'b0, modelCmd};
      axilPkg::offResult: return {axilPkg::respOkay, alu[31:0]};
      axilPkg::offFlags: return {axilPkg::respOkay, 29'b0, alu[34:32]};
      default:           return {axilPkg::respSlvErr, 32'b0};
    endcase
  endfunction

  task automatic applyWrite(logic [7:0] addr, logic [31:0] data, logic [3:0] strb);
    logic [31:0] mask;
    logic        mapped;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    mapped = 1'b1;
    case (addr)
      axilPkg::offOpA: modelA = (modelA & ~mask) | (data & mask);
      axilPkg::offOpB: modelB = (modelB & ~mask) | (data & mask);
      axilPkg::offCmd: begin
        if (strb[0]) begin
          modelCmd = data[2:0];
        end
      end
      default: mapped = 1'b0;
    endcase
    expB.push_back(mapped ? axilPkg::respOkay : axilPkg::respSlvErr);
  endtask

  task automatic noteFailure(string msg);
    $display("%s: %s", testName(lastTestId), msg);
    errorCount++;
    testErrors++;
  endtask

  task automatic compare(string what, logic [31:0] exp, logic [31:0] act);
    testChecks++;
    if (exp !== act) begin
      $display("ERROR %s/%s expected %h actual %h", testName(lastTestId), what, exp, act);
      errorCount++;
      testErrors++;
    end
  endtask

  always @(posedge clk) begin
    if (testId != lastTestId) begin
      if (lastTestId >= 0) begin
        testsRun++;
        if (testErrors != 0) begin
          testsFailed++;
        end
        $display("%-12s %s  checks %0d  errors %0d", testName(lastTestId),
                 (testErrors == 0) ? "ok" : "FAILED", testChecks, testErrors);
      end
      lastTestId = testId;
      testChecks = 0;
      testErrors = 0;
    end
    if (!rstN) begin
      modelA = '0;
      modelB = '0;
      modelCmd = 3'd0;
      heldValid = 1'b0;
      expRd.delete();
      expB.delete();
    end else begin
      if (heldValid && rsp.rvalid && rsp.rdata !== heldData) begin
        noteFailure("read data changed while waiting for rready");
      end
      heldValid = rsp.rvalid && !req.rready;
      heldData = rsp.rdata;
      if (rsp.awready !== rsp.wready) begin
        noteFailure("awready and wready did not pulse together");
      end
      // read is modelled before a write on the same edge lands
      if (rsp.arready && req.arvalid) begin
        expRd.push_back(readModel(req.araddr));
      end
      if (rsp.awready && rsp.wready && req.awvalid && req.wvalid) begin
        applyWrite(req.awaddr, req.wdata, req.wstrb);
      end
      if (rsp.bvalid && req.bready) begin
        if (expB.size() == 0) begin
          noteFailure("write response arrived with no write outstanding");
        end else begin
          expected[1:0] = expB.pop_front();
          compare("bresp", {30'b0, expected[1:0]}, {30'b0, rsp.bresp});
        end
      end
      if (rsp.rvalid && req.rready) begin
        if (expRd.size() == 0) begin
          noteFailure("read response arrived with no read outstanding");
        end else begin
          expected = expRd.pop_front();
          compare("rdata", expected[31:0], rsp.rdata);
          compare("rresp", {30'b0, expected[33:32]}, {30'b0, rsp.rresp});
        end
      end
    end
  end

endmodule

// ==== tb/tbAluSubsystem.sv ====
`timescale 1ns/1ps

module tbAluSubsystem;

  localparam int numArith = 200;
  localparam int numLogic = 100;
  localparam int numStrobe = 40;
  localparam int numBp = 20;
  // reset reads, five per ALU op, strobe loop, decode test, back-pressure pairs
  localparam int numTx = 2 + (numArith + 3) * 5 + numLogic * 5 + numStrobe * 5 + 9 + numBp * 2;
  localparam int timeoutCycles = numTx * 20 + 200;

  logic             clk;
  logic             rstN;
  axilPkg::axilReqT req;
  axilPkg::axilRspT rsp;
  int               testId;
  int               maxDelay;
  int               errorCount;
  int               testsRun;
  int               testsFailed;

  aluSubsystem #(
    .addrWidth (8)
  ) u_aluSubsystem (
    .clk  (clk),
    .rstN (rstN),
    .req  (req),
    .rsp  (rsp)
  );

  aluScoreboard u_scoreboard (
    .clk         (clk),
    .rstN        (rstN),
    .req         (req),
    .rsp         (rsp),
    .testId      (testId),
    .errorCount  (errorCount),
    .testsRun    (testsRun),
    .testsFailed (testsFailed)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // both bus tasks start and end just after a falling edge
  task automatic axiWrite(logic [7:0] addr, logic [31:0] data, logic [3:0] strb);
    req.awvalid = 1'b1;
    req.awaddr = addr;
    req.wvalid = 1'b1;
    req.wdata = data;
    req.wstrb = strb;
    do @(negedge clk); while (!rsp.awready);
    @(negedge clk);
    req.awvalid = 1'b0;
    req.wvalid = 1'b0;
    repeat ($urandom_range(maxDelay)) @(negedge clk);
    req.bready = 1'b1;
    while (!rsp.bvalid) @(negedge clk);
    @(negedge clk);
    req.bready = 1'b0;
  endtask

  task automatic axiRead(logic [7:0] addr);
    req.arvalid = 1'b1;
    req.araddr = addr;
    do @(negedge clk); while (!rsp.arready);
    @(negedge clk);
    req.arvalid = 1'b0;
    repeat ($urandom_range(maxDelay)) @(negedge clk);
    req.rready = 1'b1;
    while (!rsp.rvalid) @(negedge clk);
    @(negedge clk);
    req.rready = 1'b0;
  endtask

  task automatic runOp(logic [31:0] a, logic [31:0] b, logic [2:0] cmd);
    logic [31:0] cmdWord;
    // junk in the upper bits must not reach the cmd register
    cmdWord = $urandom();
    cmdWord[2:0] = cmd;
    axiWrite(axilPkg::offOpA, a, 4'hf);
    axiWrite(axilPkg::offOpB, b, 4'hf);
    axiWrite(axilPkg::offCmd, cmdWord, 4'hf);
    axiRead(axilPkg::offResult);
    axiRead(axilPkg::offFlags);
  endtask

  initial begin
    void'($urandom(32'h7ee9));
    req = '0;
    rstN = 1'b0;
    testId = 0;
    maxDelay = 3;
    repeat (3) @(negedge clk);
    rstN = 1'b1;
    @(negedge clk);

    axiRead(axilPkg::offResult);
    axiRead(axilPkg::offFlags);

    testId = 1;
    runOp(32'h1234_5678, 32'h1234_5678, aluPkg::cmdAdd);
    runOp(32'h1234_5678, 32'h1234_5678, aluPkg::cmdSub);
    runOp(32'h7fff_ffff, 32'h0000_0001, aluPkg::cmdAdd);
    for (int i = 0; i < numArith; i++) begin
      runOp($urandom(), $urandom(), 3'($urandom_range(1, 0)));
    end

    testId = 2;
    for (int i = 0; i < numLogic; i++) begin
      runOp($urandom(), $urandom(), 3'($urandom_range(7, 2)));
    end

    testId = 3;
    for (int i = 0; i < numStrobe; i++) begin
      axiWrite(axilPkg::offOpA, $urandom(), 4'($urandom()));
      axiWrite(axilPkg::offOpB, $urandom(), 4'($urandom()));
      axiRead(axilPkg::offOpA);
      axiRead(axilPkg::offOpB);
      axiRead(axilPkg::offResult);
    end

    testId = 4;
    axiWrite(axilPkg::offResult, $urandom(), 4'hf);
    axiWrite(axilPkg::offFlags, $urandom(), 4'hf);
    axiWrite(8'h14, $urandom(), 4'hf);
    axiWrite(8'h40, $urandom(), 4'hf);
    axiRead(axilPkg::offOpA);
    axiRead(axilPkg::offOpB);
    axiRead(axilPkg::offCmd);
    axiRead(8'h14);
    axiRead(8'hfc);

    // longer stalls on bready and rready
    testId = 5;
    maxDelay = 12;
    for (int i = 0; i < numBp; i++) begin
      axiWrite(axilPkg::offOpA, $urandom(), 4'hf);
      axiRead(axilPkg::offResult);
    end

    testId = -1;
    repeat (2) @(negedge clk);
    $display("tests %0d  failed %0d  errors %0d", testsRun, testsFailed, errorCount);
    if (errorCount == 0 && testsFailed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    repeat (timeoutCycles) @(posedge clk);
    $display("timeout: bus transactions did not complete within %0d cycles", timeoutCycles);
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== src.f ====
src/aluPkg.sv
src/axilPkg.sv
src/aluControlLut.sv
src/addSub.sv
src/aluOutputSelect.sv
src/aluCore.sv
src/aluAxilRegs.sv
src/aluSubsystem.sv
tb/aluScoreboard.sv
tb/tbAluSubsystem.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f src.f --top-module tbAluSubsystem -o simAlu \
  && ./obj_dir/simAlu > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0
